// ==== all.f ====
+incdir+include
hdl/l2_cache_pkg.sv
hdl/way_array.sv
hdl/hit_detect.sv
hdl/victim_select.sv
hdl/l2_cache_fsm.sv
hdl/l2_cache_ctrl.sv
verification/tb_mem_model.sv
verification/tb_l2_cache_ctrl.sv

// ==== hdl/hit_detect.sv ====
// ================================================
// hit detect
// tag compare across all ways, hit way and line,
// read word extract and write word merge
// ================================================

`timescale 1ns/1ps

`include "l2_cache_config.svh"

module hit_detect (
    input  l2_cache_pkg::l2_addr_t                addr,
    input  l2_cache_pkg::way_status_t             status,
    input  l2_cache_pkg::line_t [`L2_WAYS-1:0]    lines,
    input  l2_cache_pkg::word_t                   wdata,
    output logic                                  hit,
    output l2_cache_pkg::way_t                    hit_way,
    output l2_cache_pkg::word_t                   rd_word,
    output l2_cache_pkg::line_t                   merged_line
);

    import l2_cache_pkg::*;

    logic [`L2_WAYS-1:0] match;
    line_t               hit_line;

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            match[w] = status.entry[w].valid && (status.entry[w].tag == addr.tag);
        end
    end

    // lowest matching way wins
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        hit_line = lines[0];
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit      = 1'b1;
                hit_way  = way_t'(w);
                hit_line = lines[w];
            end
        end
    end

    always_comb begin
        rd_word     = hit_line[addr.word_sel * `L2_WORD_W +: `L2_WORD_W];
        merged_line = hit_line;
        merged_line[addr.word_sel * `L2_WORD_W +: `L2_WORD_W] = wdata;
    end

endmodule

// ==== hdl/l2_cache_ctrl.sv ====
// ================================================
// l2 cache controller top
// request capture, array read index steering,
// valid-bit clear sweep after reset, instances
// ================================================

`timescale 1ns/1ps

`include "l2_cache_config.svh"

module l2_cache_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req,
    input  l2_cache_pkg::l2_req_t   req_data,
    output logic                    busy,
    output logic                    rdy,
    output l2_cache_pkg::word_t     rdata,
    output logic                    miss_stall,
    output logic                    mem_req,
    output l2_cache_pkg::mem_req_t  mem,
    input  logic                    mem_complete,
    input  l2_cache_pkg::line_t     mem_rdata
);

    import l2_cache_pkg::*;

    typedef struct packed {
        logic        dirty;
        tag_entry_t  entry;
    } tag_slot_t;

    l2_req_t                      cur_req;
    logic                         start;
    index_t                       rd_index;
    index_t                       wr_index;
    index_t                       sweep_idx;
    logic                         sweep_done;
    tag_slot_t [`L2_WAYS-1:0]     slot_rd;
    tag_slot_t                    slot_wr;
    logic [`L2_WAYS-1:0]          slot_we;
    line_t [`L2_WAYS-1:0]         line_rd;
    way_status_t                  status;
    logic                         hit;
    way_t                         hit_way;
    word_t                        rd_word;
    line_t                        merged_line;
    way_t                         victim_way;
    tag_entry_t                   victim_entry;
    logic                         victim_dirty;
    logic [`L2_WAYS-1:0]          fsm_tag_we;
    logic [`L2_WAYS-1:0]          data_we;
    tag_entry_t                   wr_entry;
    logic                         wr_dirty;
    line_t                        wr_line;
    logic                         plru_update;
    way_t                         used_way;

    assign start = req && !busy;

    always_ff @(posedge clk) begin
        if (start) begin
            cur_req <= req_data;
        end
    end

    // look up the new index during the accept cycle
    assign rd_index = start ? req_data.addr.index : cur_req.addr.index;

    // one set per cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_idx  <= '0;
            sweep_done <= 1'b0;
        end else if (!sweep_done) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) begin
                sweep_done <= 1'b1;
            end
        end
    end

    assign wr_index      = sweep_done ? cur_req.addr.index : sweep_idx;
    assign slot_wr.dirty = sweep_done && wr_dirty;
    assign slot_wr.entry = sweep_done ? wr_entry : '0;
    assign slot_we       = fsm_tag_we | {`L2_WAYS{!sweep_done}};

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            status.entry[w] = slot_rd[w].entry;
            status.dirty[w] = slot_rd[w].dirty;
        end
    end

    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        way_array #(.payload_t(tag_slot_t)) i_tag (
            .clk(clk), .rd_index(rd_index), .rd_payload(slot_rd[w]),
            .wr_en(slot_we[w]), .wr_index(wr_index), .wr_payload(slot_wr)
        );
        way_array #(.payload_t(line_t)) i_data (
            .clk(clk), .rd_index(rd_index), .rd_payload(line_rd[w]),
            .wr_en(data_we[w]), .wr_index(wr_index), .wr_payload(wr_line)
        );
    end

    hit_detect i_hit (
        .addr(cur_req.addr), .status(status), .lines(line_rd), .wdata(cur_req.wdata),
        .hit(hit), .hit_way(hit_way), .rd_word(rd_word), .merged_line(merged_line)
    );

    victim_select i_victim (
        .clk(clk), .reset(reset), .index(cur_req.addr.index), .status(status),
        .plru_update(plru_update), .used_way(used_way), .victim_way(victim_way),
        .victim_entry(victim_entry), .victim_dirty(victim_dirty)
    );

    l2_cache_fsm i_fsm (
        .clk(clk), .reset(reset), .start(start), .sweep_done(sweep_done),
        .cur_req(cur_req), .hit(hit), .hit_way(hit_way), .rd_word(rd_word),
        .merged_line(merged_line), .victim_way(victim_way), .victim_entry(victim_entry),
        .victim_dirty(victim_dirty), .victim_line(line_rd[victim_way]),
        .mem_complete(mem_complete), .mem_rdata(mem_rdata), .busy(busy), .rdy(rdy),
        .rdata(rdata), .miss_stall(miss_stall), .mem_req(mem_req), .mem(mem),
        .tag_we(fsm_tag_we), .data_we(data_we), .wr_entry(wr_entry), .wr_dirty(wr_dirty),
        .wr_line(wr_line), .plru_update(plru_update), .used_way(used_way)
    );

endmodule

// ==== hdl/l2_cache_fsm.sv ====
// ================================================
// l2 cache controller FSM
// hit or miss decision, write hit update,
// dirty victim write-back and line fill
// ================================================

`timescale 1ns/1ps

`include "l2_cache_config.svh"

module l2_cache_fsm (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        sweep_done,
    input  l2_cache_pkg::l2_req_t       cur_req,
    input  logic                        hit,
    input  l2_cache_pkg::way_t          hit_way,
    input  l2_cache_pkg::word_t         rd_word,
    input  l2_cache_pkg::line_t         merged_line,
    input  l2_cache_pkg::way_t          victim_way,
    input  l2_cache_pkg::tag_entry_t    victim_entry,
    input  logic                        victim_dirty,
    input  l2_cache_pkg::line_t         victim_line,
    input  logic                        mem_complete,
    input  l2_cache_pkg::line_t         mem_rdata,
    output logic                        busy,
    output logic                        rdy,
    output l2_cache_pkg::word_t         rdata,
    output logic                        miss_stall,
    output logic                        mem_req,
    output l2_cache_pkg::mem_req_t      mem,
    output logic [`L2_WAYS-1:0]         tag_we,
    output logic [`L2_WAYS-1:0]         data_we,
    output l2_cache_pkg::tag_entry_t    wr_entry,
    output logic                        wr_dirty,
    output l2_cache_pkg::line_t         wr_line,
    output logic                        plru_update,
    output l2_cache_pkg::way_t          used_way
);

    import l2_cache_pkg::*;

    l2_state_t state_q;
    l2_state_t state_d;
    logic      refetch_q;     // arrays still show pre-fill contents
    logic      decide;
    logic      fill_done;
    logic      evict;
    mem_req_t  fetch_req;
    mem_req_t  evict_req;

    assign decide    = (state_q == ST_ACCESS) && !refetch_q;
    assign fill_done = (state_q == ST_FILL) && mem_complete;
    assign evict     = victim_entry.valid && victim_dirty;
    assign busy      = (state_q != ST_IDLE) || !sweep_done;

    always_comb begin
        fetch_req.write           = 1'b0;
        fetch_req.line_addr.tag   = cur_req.addr.tag;
        fetch_req.line_addr.index = cur_req.addr.index;
        fetch_req.wline           = '0;
        evict_req.write           = 1'b1;
        evict_req.line_addr.tag   = victim_entry.tag;   // victim's own address
        evict_req.line_addr.index = cur_req.addr.index;
        evict_req.wline           = victim_line;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = ST_ACCESS;
                end
            end
            ST_ACCESS: begin
                if (decide && hit) begin
                    state_d = cur_req.write ? ST_WRITE_HIT : ST_IDLE;
                end else if (decide) begin
                    state_d = evict ? ST_WRITE_MEM : ST_FILL;
                end
            end
            ST_WRITE_HIT: state_d = ST_IDLE;
            ST_WRITE_MEM: begin
                if (mem_complete) begin
                    state_d = ST_FILL;
                end
            end
            ST_FILL: begin
                if (mem_complete) begin
                    state_d = ST_ACCESS;   // replay as a hit
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // array writes happen in the cycle the state is held
    always_comb begin
        tag_we         = '0;
        wr_entry.valid = 1'b1;
        wr_entry.tag   = cur_req.addr.tag;
        wr_dirty       = 1'b0;
        wr_line        = mem_rdata;
        plru_update    = decide && hit;
        used_way       = hit_way;
        if (state_q == ST_WRITE_HIT) begin
            tag_we[hit_way] = 1'b1;
            wr_dirty        = 1'b1;
            wr_line         = merged_line;
        end else if (fill_done) begin
            tag_we[victim_way] = 1'b1;
            plru_update        = 1'b1;
            used_way           = victim_way;
        end
    end

    assign data_we = tag_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= ST_IDLE;
            refetch_q  <= 1'b0;
            rdy        <= 1'b0;
            miss_stall <= 1'b0;
            mem_req    <= 1'b0;
        end else begin
            state_q   <= state_d;
            refetch_q <= fill_done;
            rdy       <= decide && hit;   // one-cycle pulse
            if (decide && !hit) begin
                miss_stall <= 1'b1;
                mem_req    <= 1'b1;
            end else if (fill_done) begin
                miss_stall <= 1'b0;
                mem_req    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decide && hit) begin
            rdata <= rd_word;
        end
        if (decide && !hit) begin
            mem <= evict ? evict_req : fetch_req;
        end else if (state_q == ST_WRITE_MEM && mem_complete) begin
            mem <= fetch_req;   // write-back done, now read
        end
    end

endmodule

// ==== hdl/l2_cache_pkg.sv ====
// ================================================
// l2 cache types
// address fields, tag entries, lines, requests
// and controller states shared by all blocks
// ================================================

`include "l2_cache_config.svh"

package l2_cache_pkg;

    typedef logic [`L2_TAG_W-1:0]                          tag_t;
    typedef logic [`L2_INDEX_W-1:0]                        index_t;
    typedef logic [`L2_LINE_OFF_W-`L2_WORD_SEL_LSB-1:0]    word_sel_t;
    typedef logic [`L2_LINE_W-1:0]                         line_t;
    typedef logic [`L2_WORD_W-1:0]                         word_t;
    typedef logic [$clog2(`L2_WAYS)-1:0]                   way_t;
    typedef logic [`L2_WAYS-2:0]                           plru_t;   // tree bits

    typedef struct packed {
        tag_t                         tag;
        index_t                       index;
        word_sel_t                    word_sel;
        logic [`L2_WORD_SEL_LSB-1:0]  byte_off;   // ignored
    } l2_addr_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
    } tag_entry_t;

    typedef struct packed {
        l2_addr_t  addr;
        logic      write;
        word_t     wdata;
    } l2_req_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
    } line_addr_t;

    typedef struct packed {
        logic        write;
        line_addr_t  line_addr;
        line_t       wline;      // victim data on write-back
    } mem_req_t;

    typedef struct packed {
        tag_entry_t [`L2_WAYS-1:0]  entry;
        logic [`L2_WAYS-1:0]        dirty;
    } way_status_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_WRITE_HIT,
        ST_WRITE_MEM,
        ST_FILL
    } l2_state_t;

endpackage

// ==== hdl/victim_select.sv ====
// ================================================
// victim select
// per-set pseudo-LRU tree and the replacement
// choice: first invalid way, else the tree
// ================================================

`timescale 1ns/1ps

`include "l2_cache_config.svh"

module victim_select (
    input  logic                       clk,
    input  logic                       reset,
    input  l2_cache_pkg::index_t       index,
    input  l2_cache_pkg::way_status_t  status,
    input  logic                       plru_update,
    input  l2_cache_pkg::way_t         used_way,
    output l2_cache_pkg::way_t         victim_way,
    output l2_cache_pkg::tag_entry_t   victim_entry,
    output logic                       victim_dirty
);

    import l2_cache_pkg::*;

    plru_t plru_q [`L2_SETS];
    plru_t bits;

    always_comb begin
        bits = plru_q[index];
        if (!bits[0]) begin
            victim_way = bits[1] ? 2'd1 : 2'd0;   // left half
        end else begin
            victim_way = bits[2] ? 2'd3 : 2'd2;   // right half
        end
        // an empty way overrides the tree
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (!status.entry[w].valid) begin
                victim_way = way_t'(w);
            end
        end
        victim_entry = status.entry[victim_way];
        victim_dirty = status.dirty[victim_way];
    end

    // point the path away from the way just used
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else if (plru_update) begin
            if (!used_way[1]) begin
                plru_q[index][0] <= 1'b1;
                plru_q[index][1] <= !used_way[0];
            end else begin
                plru_q[index][0] <= 1'b0;
                plru_q[index][2] <= !used_way[0];
            end
        end
    end

endmodule

// ==== hdl/way_array.sv ====
// ================================================
// way array
// one way of the cache, one entry per set
// synchronous read, single write port
// ================================================

`timescale 1ns/1ps

`include "l2_cache_config.svh"

module way_array #(
    parameter type payload_t = logic
) (
    input  logic                  clk,
    input  l2_cache_pkg::index_t  rd_index,
    output payload_t              rd_payload,
    input  logic                  wr_en,
    input  l2_cache_pkg::index_t  wr_index,
    input  payload_t              wr_payload
);

    payload_t mem [`L2_SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_payload;
        end
        rd_payload <= mem[rd_index];   // old data on same-index write
    end

endmodule

// ==== include/l2_cache_config.svh ====
// ================================================
// l2 cache geometry
// address split, line and word sizes, way count
// for the four-way write-back second-level cache
// ================================================

`ifndef L2_CACHE_CONFIG_SVH
`define L2_CACHE_CONFIG_SVH

`define L2_ADDR_W        32    // byte address
`define L2_LINE_W        512   // one cache line
`define L2_WORD_W        128   // one cpu word
`define L2_WAYS          4
`define L2_INDEX_W       9     // address bits 14..6
`define L2_TAG_W         17    // address bits 31..15
`define L2_WORD_SEL_LSB  4     // low bit of word select

// derived values
`define L2_LINE_OFF_W    (`L2_ADDR_W - `L2_TAG_W - `L2_INDEX_W)
`define L2_SETS          (1 << `L2_INDEX_W)

`endif

// ==== run.sh ====
#!/bin/sh
# builds the l2 cache testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_l2_cache_ctrl \
    -f all.f > build.log 2>&1 &&
./obj_dir/Vtb_l2_cache_ctrl > sim.log 2>&1 ||
echo "build or simulation returned an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "STATUS: FAIL" sim.log 2>/dev/null && exit 1
grep -q "STATUS: PASS" sim.log 2>/dev/null || exit 1
exit 0

// ==== verification/tb_l2_cache_ctrl.sv ====
// ================================================
// l2 cache controller testbench
// directed hit, miss and eviction cases, then
// random reads and writes against a word model
// ================================================

`timescale 1ns/1ps

module tb_l2_cache_ctrl;

    import l2_cache_pkg::*;

    localparam int SWEEP_TIMEOUT = 2000;
    localparam int REQ_TIMEOUT   = 400;

    logic         clk;
    logic         reset;
    logic         req;
    l2_req_t      req_data;
    logic         busy;
    logic         rdy;
    word_t        rdata;
    logic         miss_stall;
    logic         mem_req;
    mem_req_t     mem;
    logic         mem_complete;
    line_t        mem_rdata;
    int unsigned  wb_count;
    line_addr_t   wb_addr;
    line_t        wb_line;

    word_t        ref_mem [logic [27:0]];   // last written word per word address
    word_t        got;
    int           lat;
    logic         stalled;

    always #50 clk = ~clk;

    l2_cache_ctrl i_dut (
        .clk(clk), .reset(reset), .req(req), .req_data(req_data), .busy(busy),
        .rdy(rdy), .rdata(rdata), .miss_stall(miss_stall), .mem_req(mem_req),
        .mem(mem), .mem_complete(mem_complete), .mem_rdata(mem_rdata)
    );

    tb_mem_model i_mem (
        .clk(clk), .reset(reset), .mem_req(mem_req), .mem(mem),
        .mem_complete(mem_complete), .mem_rdata(mem_rdata), .wb_count(wb_count),
        .wb_addr(wb_addr), .wb_line(wb_line)
    );

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act === exp) else
            report_fail($sformatf("FAILED %s expected %0h actual %0h", name, exp, act));
    endtask

    // returns on a falling edge with busy low
    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (busy) begin
            assert (n < limit) else report_fail("busy did not fall before the timeout");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic run_request(input logic write, input logic [31:0] addr,
                               input word_t wdata, output word_t data,
                               output int cycles, output logic stall);
        int n;
        wait_idle(REQ_TIMEOUT);
        req            = 1'b1;
        req_data.addr  = l2_addr_t'(addr);
        req_data.write = write;
        req_data.wdata = wdata;
        @(negedge clk);
        req   = 1'b0;
        n     = 1;
        stall = miss_stall;
        check_value("busy_after_accept", 1, busy);
        while (!rdy) begin
            assert (n < REQ_TIMEOUT) else report_fail("no rdy pulse before the timeout");
            @(negedge clk);
            n++;
            stall = stall | miss_stall;
        end
        data   = rdata;
        cycles = n;   // falling edges from request to rdy
    endtask

    task automatic write_word(input logic [31:0] addr, input word_t wdata);
        run_request(1'b1, addr, wdata, got, lat, stalled);
        ref_mem[addr[31:4]] = wdata;
    endtask

    task automatic read_word(input string name, input logic [31:0] addr);
        word_t exp;
        exp = ref_mem.exists(addr[31:4]) ? ref_mem[addr[31:4]] : '0;
        run_request(1'b0, addr, '0, got, lat, stalled);
        check_value(name, exp, got);
    endtask

    function automatic logic [31:0] make_addr(input tag_t tag, input index_t index,
                                              input logic [1:0] sel);
        return {tag, index, sel, 4'h0};
    endfunction

    function automatic word_t rand_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    initial begin
        word_t        words [5];
        tag_t         evict_tags [5];
        tag_t         pool [8];
        index_t       sets [3];
        int unsigned  wb_before;
        logic [31:0]  addr;
        void'($urandom(32'h9f1fd838));
        clk      = 1'b0;
        reset    = 1'b1;
        req      = 1'b0;
        req_data = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        wait_idle(SWEEP_TIMEOUT);
        check_value("reset_rdy", 0, rdy);
        check_value("reset_miss_stall", 0, miss_stall);
        check_value("reset_mem_req", 0, mem_req);

        addr = make_addr(17'h00123, 9'd5, 2'd2);
        read_word("unwritten_read", addr);
        write_word(addr, rand_word());
        read_word("read_after_write", addr);

        read_word("resident_read", addr);
        check_value("read_hit_latency", 2, lat);
        check_value("read_hit_stall", 0, stalled);
        write_word(addr, rand_word());
        check_value("write_hit_latency", 2, lat);
        read_word("read_after_write_hit", addr);

        // ways of a fresh set fill 0..3 in order and leave the tree on way 0
        for (int k = 0; k < 5; k++) begin
            evict_tags[k] = tag_t'(17'h01000 + k * 17'h00111);
            words[k]      = rand_word();
        end
        for (int k = 0; k < 4; k++) begin
            write_word(make_addr(evict_tags[k], 9'd100, 2'(k)), words[k]);
        end
        wb_before = wb_count;
        write_word(make_addr(evict_tags[4], 9'd100, 2'd0), words[4]);
        check_value("evict_wb_count", wb_before + 1, wb_count);
        check_value("evict_wb_addr", {evict_tags[0], 9'd100}, wb_addr);
        check_value("evict_wb_word", words[0], wb_line[127:0]);
        read_word("evicted_read", make_addr(evict_tags[0], 9'd100, 2'd0));
        check_value("evicted_read_stall", 1, stalled);

        for (int i = 0; i < 8; i++) begin
            pool[i] = tag_t'($urandom);
        end
        sets[0] = 9'd3;
        sets[1] = 9'd77;
        sets[2] = 9'd300;
        for (int i = 0; i < 2000; i++) begin
            addr = make_addr(pool[$urandom_range(7, 0)], sets[$urandom_range(2, 0)],
                             2'($urandom_range(3, 0)));
            if ($urandom_range(1, 0) == 1) begin
                write_word(addr, rand_word());
            end else begin
                read_word($sformatf("random_read_%0d", i), addr);
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== verification/tb_mem_model.sv ====
// ================================================
// backing memory model
// line store behind the l2 cache, random complete
// latency and a record of the write-backs
// ================================================

`timescale 1ns/1ps

module tb_mem_model (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mem_req,
    input  l2_cache_pkg::mem_req_t      mem,
    output logic                        mem_complete,
    output l2_cache_pkg::line_t         mem_rdata,
    output int unsigned                 wb_count,
    output l2_cache_pkg::line_addr_t    wb_addr,
    output l2_cache_pkg::line_t         wb_line
);

    import l2_cache_pkg::*;

    line_t     store [logic [$bits(line_addr_t)-1:0]];   // unwritten lines read as zero
    mem_req_t  cur;
    logic      pending;
    int        delay;

    initial begin
        mem_complete = 1'b0;
        mem_rdata    = '0;
        wb_count     = 0;
        wb_addr      = '0;
        wb_line      = '0;
        pending      = 1'b0;
        delay        = 0;
        forever begin
            @(negedge clk);
            mem_complete = 1'b0;   // one-cycle pulse
            if (reset) begin
                pending = 1'b0;
            end else if (pending && delay > 0) begin
                delay--;
            end else if (pending) begin
                pending      = 1'b0;
                mem_complete = 1'b1;
                if (cur.write) begin
                    store[cur.line_addr] = cur.wline;
                    wb_count++;
                    wb_addr = cur.line_addr;   // latest write-back
                    wb_line = cur.wline;
                end else if (store.exists(cur.line_addr)) begin
                    mem_rdata = store[cur.line_addr];
                end else begin
                    mem_rdata = '0;
                end
            end else if (mem_req) begin
                pending = 1'b1;
                cur     = mem;   // held stable while mem_req is high
                delay   = $urandom_range(7, 0);
            end
        end
    end

endmodule
